// ==== lane_pkg.sv ====
`default_nettype none

package lane_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // One 64-bit element and its byte enables
  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;

  // Register index, 32 vector registers
  typedef logic [4:0] vreg_t;

  // Lane-local element address, register * ElemsPerReg + index
  typedef logic [8:0] vaddr_t;

  // Element count, 1 to 16
  typedef logic [4:0] vlen_t;

  typedef logic [2:0] vid_t;

  // ALU_A, ALU_B and STU
  localparam int unsigned NrOpQueues = 3;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    VALU,
    VSTORE
  } insn_kind_e;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR
  } alu_op_e;

  typedef enum logic [1:0] {
    ALU_A,
    ALU_B,
    STU
  } opqueue_e;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // A store streams out register vs1
  typedef struct packed {
    vid_t       id;
    insn_kind_e kind;
    alu_op_e    alu_op;
    vreg_t      vd;
    vreg_t      vs1;
    vreg_t      vs2;
    vlen_t      vl;
  } pe_req_t;

  typedef struct packed {
    logic done;
    vid_t id;
  } pe_resp_t;

  typedef struct packed {
    alu_op_e alu_op;
    vreg_t   vd;
    vlen_t   vl;
    vid_t    id;
  } vfu_op_t;

  typedef struct packed {
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } vrf_wreq_t;

endpackage : lane_pkg

`default_nettype wire

// ==== operand_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_queue import lane_pkg::*; #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  elen_t data_i,
  output logic  ready_o,
  output elen_t data_o,
  output logic  valid_o,
  input  logic  pop_i
);

  localparam int unsigned PtrW = $clog2(QueueDepth);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [PtrW:0]   cnt_t;

  elen_t mem_q [QueueDepth];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  cnt_q;
  logic  do_pop;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(QueueDepth - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  assign valid_o = (cnt_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign do_pop  = pop_i && valid_o;

  // Two spare slots, one of them for a read still in the VRF
  assign ready_o = (cnt_q <= cnt_t'(QueueDepth - 2));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push_i && !do_pop) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (!push_i && do_pop) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

endmodule : operand_queue

`default_nettype wire

// ==== vector_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module vector_regfile import lane_pkg::*; #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Per-bank access, addr is the row inside the bank
  input  logic     [NrBanks-1:0]    req_i,
  input  logic     [NrBanks-1:0]    wen_i,
  input  vaddr_t   [NrBanks-1:0]    addr_i,
  input  elen_t    [NrBanks-1:0]    wdata_i,
  input  strb_t    [NrBanks-1:0]    be_i,
  input  opqueue_e [NrBanks-1:0]    tgt_i,
  // Read data steered to the queues
  output elen_t    [NrOpQueues-1:0] operand_o,
  output logic     [NrOpQueues-1:0] operand_valid_o
);

  localparam int unsigned RowW  = $bits(vaddr_t) - $clog2(NrBanks);
  localparam int unsigned Depth = 2 ** RowW;

  elen_t    rdata_q  [NrBanks];
  logic     rvalid_q [NrBanks];
  opqueue_e rtgt_q   [NrBanks];

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    elen_t           mem_q [Depth];
    logic [RowW-1:0] row;

    assign row = addr_i[b][RowW-1:0];

    always_ff @(posedge clk_i) begin
      if (req_i[b] && wen_i[b]) begin
        for (int i = 0; i < $bits(strb_t); i++) begin
          if (be_i[b][i]) mem_q[row][8*i +: 8] <= wdata_i[b][8*i +: 8];
        end
      end
      if (req_i[b] && !wen_i[b]) begin
        rdata_q[b] <= mem_q[row];
      end
    end

    // Tag travels with the read data
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rvalid_q[b] <= 1'b0;
        rtgt_q[b]   <= ALU_A;
      end else begin
        rvalid_q[b] <= req_i[b] && !wen_i[b];
        if (req_i[b] && !wen_i[b]) rtgt_q[b] <= tgt_i[b];
      end
    end
  end

  // At most one bank answers each queue per cycle
  always_comb begin
    operand_o       = '0;
    operand_valid_o = '0;
    for (int b = 0; b < NrBanks; b++) begin
      if (rvalid_q[b]) begin
        operand_o[rtgt_q[b]]       = rdata_q[b];
        operand_valid_o[rtgt_q[b]] = 1'b1;
      end
    end
  end

endmodule : vector_regfile

`default_nettype wire

// ==== operand_requester.sv ====
`timescale 1ns/1ns
`default_nettype none

// Bank mapping needs ElemsPerReg >= NrBanks >= 2
module operand_requester import lane_pkg::*; #(
  parameter int unsigned NrBanks     = 4,
  parameter int unsigned ElemsPerReg = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Lane sequencer
  input  logic                   rd_req_i,
  input  logic                   rd_stu_i,
  input  vaddr_t                 rd_vs1_i,
  input  vaddr_t                 rd_vs2_i,
  output logic                   rd_ready_o,
  input  logic [NrOpQueues-1:0]  q_ready_i,
  // Write sources
  input  logic                   alu_wr_req_i,
  input  vrf_wreq_t              alu_wr_i,
  output logic                   alu_wr_gnt_o,
  input  logic                   ldu_wr_req_i,
  input  vrf_wreq_t              ldu_wr_i,
  output logic                   ldu_wr_gnt_o,
  // VRF banks
  output logic     [NrBanks-1:0] bank_req_o,
  output logic     [NrBanks-1:0] bank_wen_o,
  output vaddr_t   [NrBanks-1:0] bank_addr_o,
  output elen_t    [NrBanks-1:0] bank_wdata_o,
  output strb_t    [NrBanks-1:0] bank_be_o,
  output opqueue_e [NrBanks-1:0] bank_tgt_o
);

  localparam int unsigned IdxW  = $clog2(ElemsPerReg);
  localparam int unsigned BankW = $clog2(NrBanks);

  typedef logic [BankW-1:0] bank_t;

  // Bank is (index + register) mod NrBanks
  function automatic bank_t bank_of(vaddr_t addr);
    return bank_t'(addr[IdxW-1:0]) + bank_t'(addr >> IdxW);
  endfunction

  function automatic vaddr_t row_of(vaddr_t addr);
    return addr >> BankW;
  endfunction

  bank_t              bank_alu;
  bank_t              bank_ldu;
  bank_t              bank_a;
  bank_t              bank_b;
  logic [NrBanks-1:0] wr_busy;
  logic               same_bank;
  logic               a_sent_q;
  logic               issue_stu;
  logic               issue_a;
  logic               issue_b;

  assign bank_alu  = bank_of(alu_wr_i.addr);
  assign bank_ldu  = bank_of(ldu_wr_i.addr);
  assign bank_a    = bank_of(rd_vs1_i);
  assign bank_b    = bank_of(rd_vs2_i);
  assign same_bank = (bank_a == bank_b);

  //////////////////////////////////////////////////////////////////////
  // Priority: ALU write, load write, STU read, ALU reads
  //////////////////////////////////////////////////////////////////////

  assign alu_wr_gnt_o = alu_wr_req_i;
  assign ldu_wr_gnt_o = ldu_wr_req_i && !(alu_wr_req_i && bank_alu == bank_ldu);

  always_comb begin
    wr_busy = '0;
    if (alu_wr_req_i) wr_busy[bank_alu] = 1'b1;
    if (ldu_wr_gnt_o) wr_busy[bank_ldu] = 1'b1;
  end

  assign issue_stu = rd_req_i && rd_stu_i && q_ready_i[STU] && !wr_busy[bank_a];

  // A and B go together, except when both sit in one bank, then A first
  assign issue_a = rd_req_i && !rd_stu_i && !a_sent_q && q_ready_i[ALU_A] &&
                   !wr_busy[bank_a] && (same_bank || (q_ready_i[ALU_B] && !wr_busy[bank_b]));
  assign issue_b = rd_req_i && !rd_stu_i && q_ready_i[ALU_B] && !wr_busy[bank_b] &&
                   (a_sent_q || (!same_bank && issue_a));

  assign rd_ready_o = issue_stu || issue_b;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_sent_q <= 1'b0;
    end else if (issue_b) begin
      a_sent_q <= 1'b0;
    end else if (issue_a) begin
      a_sent_q <= 1'b1;
    end
  end

  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      bank_req_o[b]   = 1'b0;
      bank_wen_o[b]   = 1'b0;
      bank_addr_o[b]  = '0;
      bank_wdata_o[b] = '0;
      bank_be_o[b]    = '0;
      bank_tgt_o[b]   = ALU_A;
      if (alu_wr_req_i && bank_alu == bank_t'(b)) begin
        bank_req_o[b]   = 1'b1;
        bank_wen_o[b]   = 1'b1;
        bank_addr_o[b]  = row_of(alu_wr_i.addr);
        bank_wdata_o[b] = alu_wr_i.wdata;
        bank_be_o[b]    = alu_wr_i.be;
      end else if (ldu_wr_gnt_o && bank_ldu == bank_t'(b)) begin
        bank_req_o[b]   = 1'b1;
        bank_wen_o[b]   = 1'b1;
        bank_addr_o[b]  = row_of(ldu_wr_i.addr);
        bank_wdata_o[b] = ldu_wr_i.wdata;
        bank_be_o[b]    = ldu_wr_i.be;
      end else if (issue_stu && bank_a == bank_t'(b)) begin
        bank_req_o[b]  = 1'b1;
        bank_addr_o[b] = row_of(rd_vs1_i);
        bank_tgt_o[b]  = STU;
      end else if (issue_a && bank_a == bank_t'(b)) begin
        bank_req_o[b]  = 1'b1;
        bank_addr_o[b] = row_of(rd_vs1_i);
        bank_tgt_o[b]  = ALU_A;
      end else if (issue_b && bank_b == bank_t'(b)) begin
        bank_req_o[b]  = 1'b1;
        bank_addr_o[b] = row_of(rd_vs2_i);
        bank_tgt_o[b]  = ALU_B;
      end
    end
  end

endmodule : operand_requester

`default_nettype wire

// ==== vector_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module vector_alu import lane_pkg::*; #(
  parameter int unsigned ElemsPerReg = 8
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Lane sequencer
  input  vfu_op_t   vfu_op_i,
  input  logic      vfu_op_valid_i,
  output logic      done_o,
  // Operand queues
  input  elen_t     a_i,
  input  logic      a_valid_i,
  output logic      a_pop_o,
  input  elen_t     b_i,
  input  logic      b_valid_i,
  output logic      b_pop_o,
  // Writeback
  output logic      wr_req_o,
  output vrf_wreq_t wr_o,
  input  logic      wr_gnt_i
);

  localparam int unsigned IdxW = $clog2(ElemsPerReg);

  vfu_op_t op_q;
  vlen_t   elem_q;
  vlen_t   gnt_cnt_q;
  logic    res_valid_q;
  elen_t   res_q;
  vaddr_t  res_addr_q;
  elen_t   res_d;
  logic    pop;
  logic    wr_done;

  // Result register frees up in the cycle its write is granted
  assign pop     = a_valid_i && b_valid_i && (!res_valid_q || wr_gnt_i);
  assign a_pop_o = pop;
  assign b_pop_o = pop;

  always_comb begin
    unique case (op_q.alu_op)
      ADD:     res_d = a_i + b_i;
      SUB:     res_d = a_i - b_i;
      AND:     res_d = a_i & b_i;
      OR:      res_d = a_i | b_i;
      XOR:     res_d = a_i ^ b_i;
      default: res_d = '0;
    endcase
  end

  assign wr_done  = wr_gnt_i && res_valid_q;
  assign wr_req_o = res_valid_q;
  assign wr_o     = '{addr: res_addr_q, wdata: res_q, be: '1};
  assign done_o   = wr_done && (gnt_cnt_q == op_q.vl - vlen_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q        <= '0;
      elem_q      <= '0;
      gnt_cnt_q   <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (vfu_op_valid_i) begin
        op_q      <= vfu_op_i;
        elem_q    <= '0;
        gnt_cnt_q <= '0;
      end else begin
        if (pop) elem_q <= elem_q + vlen_t'(1);
        if (wr_done) gnt_cnt_q <= gnt_cnt_q + vlen_t'(1);
      end
      if (pop) begin
        res_valid_q <= 1'b1;
      end else if (wr_gnt_i) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      res_q      <= res_d;
      res_addr_q <= vaddr_t'({op_q.vd, elem_q[IdxW-1:0]});
    end
  end

endmodule : vector_alu

`default_nettype wire

// ==== lane_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module lane_sequencer import lane_pkg::*; #(
  parameter int unsigned ElemsPerReg = 8
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Main sequencer
  input  pe_req_t  pe_req_i,
  input  logic     pe_req_valid_i,
  output logic     pe_req_ready_o,
  output pe_resp_t pe_resp_o,
  // Operand requester
  output logic     rd_req_o,
  output logic     rd_stu_o,
  output vaddr_t   rd_vs1_o,
  output vaddr_t   rd_vs2_o,
  input  logic     rd_ready_i,
  // ALU
  output vfu_op_t  vfu_op_o,
  output logic     vfu_op_valid_o,
  input  logic     alu_done_i,
  // Store port handshake
  input  logic     stu_pop_i
);

  localparam int unsigned IdxW = $clog2(ElemsPerReg);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT
  } state_e;

  state_e   state_q;
  state_e   state_d;
  pe_req_t  req_q;
  vlen_t    issue_cnt_q;
  vlen_t    pop_cnt_q;
  vlen_t    last_elem;
  pe_resp_t resp_q;
  logic     accept;
  logic     is_store;
  logic     finish;

  assign pe_req_ready_o = (state_q == IDLE);
  assign accept         = pe_req_valid_i && pe_req_ready_o;
  assign is_store       = (req_q.kind == VSTORE);
  assign last_elem      = req_q.vl - vlen_t'(1);
  assign pe_resp_o      = resp_q;

  // Operands of the current element, vl never exceeds ElemsPerReg
  assign rd_req_o = (state_q == ISSUE);
  assign rd_stu_o = is_store;
  assign rd_vs1_o = vaddr_t'({req_q.vs1, issue_cnt_q[IdxW-1:0]});
  assign rd_vs2_o = vaddr_t'({req_q.vs2, issue_cnt_q[IdxW-1:0]});

  // ALU takes its operation straight from the accepted request
  assign vfu_op_o       = '{alu_op: pe_req_i.alu_op, vd: pe_req_i.vd,
                            vl: pe_req_i.vl, id: pe_req_i.id};
  assign vfu_op_valid_o = accept && (pe_req_i.kind == VALU);

  assign finish = (state_q == WAIT) &&
                  (is_store ? (stu_pop_i && pop_cnt_q == last_elem) : alu_done_i);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (accept) state_d = ISSUE;
      ISSUE:   if (rd_ready_i && issue_cnt_q == last_elem) state_d = WAIT;
      WAIT:    if (finish) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      req_q       <= '0;
      issue_cnt_q <= '0;
      pop_cnt_q   <= '0;
      resp_q      <= '0;
    end else begin
      state_q     <= state_d;
      resp_q.done <= finish;
      if (finish) begin
        resp_q.id <= req_q.id;
      end
      if (accept) begin
        req_q       <= pe_req_i;
        issue_cnt_q <= '0;
        pop_cnt_q   <= '0;
      end else begin
        if (rd_req_o && rd_ready_i) begin
          issue_cnt_q <= issue_cnt_q + vlen_t'(1);
        end
        // Store elements may already leave while reads are still issued
        if (stu_pop_i) begin
          pop_cnt_q <= pop_cnt_q + vlen_t'(1);
        end
      end
    end
  end

endmodule : lane_sequencer

`default_nettype wire

// ==== lane.sv ====
`timescale 1ns/1ns
`default_nettype none

module lane import lane_pkg::*; #(
  parameter int unsigned NrBanks     = 4,
  parameter int unsigned ElemsPerReg = 8,
  parameter int unsigned QueueDepth  = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Main sequencer
  input  pe_req_t   pe_req_i,
  input  logic      pe_req_valid_i,
  output logic      pe_req_ready_o,
  output pe_resp_t  pe_resp_o,
  // Load unit
  input  logic      ldu_result_req_i,
  input  vrf_wreq_t ldu_result_i,
  output logic      ldu_result_gnt_o,
  // Store unit
  output elen_t     stu_operand_o,
  output logic      stu_operand_valid_o,
  input  logic      stu_operand_ready_i
);

  // Sequencer side
  logic    rd_req;
  logic    rd_stu;
  logic    rd_ready;
  vaddr_t  rd_vs1;
  vaddr_t  rd_vs2;
  vfu_op_t vfu_op;
  logic    vfu_op_valid;
  logic    alu_done;
  logic    stu_pop;

  // ALU result
  logic      alu_wr_req;
  logic      alu_wr_gnt;
  vrf_wreq_t alu_wr;

  // VRF bank ports
  logic     [NrBanks-1:0] bank_req;
  logic     [NrBanks-1:0] bank_wen;
  vaddr_t   [NrBanks-1:0] bank_addr;
  elen_t    [NrBanks-1:0] bank_wdata;
  strb_t    [NrBanks-1:0] bank_be;
  opqueue_e [NrBanks-1:0] bank_tgt;

  // Operand queues
  elen_t [NrOpQueues-1:0] vrf_operand;
  logic  [NrOpQueues-1:0] vrf_operand_valid;
  logic  [NrOpQueues-1:0] q_ready;
  elen_t [NrOpQueues-1:0] q_data;
  logic  [NrOpQueues-1:0] q_valid;
  logic  [NrOpQueues-1:0] q_pop;

  assign stu_pop             = q_valid[STU] && stu_operand_ready_i;
  assign q_pop[STU]          = stu_pop;
  assign stu_operand_o       = q_data[STU];
  assign stu_operand_valid_o = q_valid[STU];

  lane_sequencer #(
    .ElemsPerReg(ElemsPerReg)
  ) i_lane_sequencer (
    .clk_i         (clk_i         ),
    .rst_ni        (rst_ni        ),
    .pe_req_i      (pe_req_i      ),
    .pe_req_valid_i(pe_req_valid_i),
    .pe_req_ready_o(pe_req_ready_o),
    .pe_resp_o     (pe_resp_o     ),
    .rd_req_o      (rd_req        ),
    .rd_stu_o      (rd_stu        ),
    .rd_vs1_o      (rd_vs1        ),
    .rd_vs2_o      (rd_vs2        ),
    .rd_ready_i    (rd_ready      ),
    .vfu_op_o      (vfu_op        ),
    .vfu_op_valid_o(vfu_op_valid  ),
    .alu_done_i    (alu_done      ),
    .stu_pop_i     (stu_pop       )
  );

  operand_requester #(
    .NrBanks    (NrBanks    ),
    .ElemsPerReg(ElemsPerReg)
  ) i_operand_requester (
    .clk_i       (clk_i           ),
    .rst_ni      (rst_ni          ),
    .rd_req_i    (rd_req          ),
    .rd_stu_i    (rd_stu          ),
    .rd_vs1_i    (rd_vs1          ),
    .rd_vs2_i    (rd_vs2          ),
    .rd_ready_o  (rd_ready        ),
    .q_ready_i   (q_ready         ),
    .alu_wr_req_i(alu_wr_req      ),
    .alu_wr_i    (alu_wr          ),
    .alu_wr_gnt_o(alu_wr_gnt      ),
    .ldu_wr_req_i(ldu_result_req_i),
    .ldu_wr_i    (ldu_result_i    ),
    .ldu_wr_gnt_o(ldu_result_gnt_o),
    .bank_req_o  (bank_req        ),
    .bank_wen_o  (bank_wen        ),
    .bank_addr_o (bank_addr       ),
    .bank_wdata_o(bank_wdata      ),
    .bank_be_o   (bank_be         ),
    .bank_tgt_o  (bank_tgt        )
  );

  vector_regfile #(
    .NrBanks(NrBanks)
  ) i_vrf (
    .clk_i          (clk_i            ),
    .rst_ni         (rst_ni           ),
    .req_i          (bank_req         ),
    .wen_i          (bank_wen         ),
    .addr_i         (bank_addr        ),
    .wdata_i        (bank_wdata       ),
    .be_i           (bank_be          ),
    .tgt_i          (bank_tgt         ),
    .operand_o      (vrf_operand      ),
    .operand_valid_o(vrf_operand_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Operand queues
  //////////////////////////////////////////////////////////////////////

  operand_queue #(
    .QueueDepth(QueueDepth)
  ) i_opq_alu_a (
    .clk_i  (clk_i                    ),
    .rst_ni (rst_ni                   ),
    .push_i (vrf_operand_valid[ALU_A] ),
    .data_i (vrf_operand[ALU_A]       ),
    .ready_o(q_ready[ALU_A]           ),
    .data_o (q_data[ALU_A]            ),
    .valid_o(q_valid[ALU_A]           ),
    .pop_i  (q_pop[ALU_A]             )
  );

  operand_queue #(
    .QueueDepth(QueueDepth)
  ) i_opq_alu_b (
    .clk_i  (clk_i                    ),
    .rst_ni (rst_ni                   ),
    .push_i (vrf_operand_valid[ALU_B] ),
    .data_i (vrf_operand[ALU_B]       ),
    .ready_o(q_ready[ALU_B]           ),
    .data_o (q_data[ALU_B]            ),
    .valid_o(q_valid[ALU_B]           ),
    .pop_i  (q_pop[ALU_B]             )
  );

  operand_queue #(
    .QueueDepth(QueueDepth)
  ) i_opq_stu (
    .clk_i  (clk_i                  ),
    .rst_ni (rst_ni                 ),
    .push_i (vrf_operand_valid[STU] ),
    .data_i (vrf_operand[STU]       ),
    .ready_o(q_ready[STU]           ),
    .data_o (q_data[STU]            ),
    .valid_o(q_valid[STU]           ),
    .pop_i  (q_pop[STU]             )
  );

  vector_alu #(
    .ElemsPerReg(ElemsPerReg)
  ) i_vector_alu (
    .clk_i         (clk_i         ),
    .rst_ni        (rst_ni        ),
    .vfu_op_i      (vfu_op        ),
    .vfu_op_valid_i(vfu_op_valid  ),
    .a_i           (q_data[ALU_A] ),
    .a_valid_i     (q_valid[ALU_A]),
    .a_pop_o       (q_pop[ALU_A]  ),
    .b_i           (q_data[ALU_B] ),
    .b_valid_i     (q_valid[ALU_B]),
    .b_pop_o       (q_pop[ALU_B]  ),
    .wr_req_o      (alu_wr_req    ),
    .wr_o          (alu_wr        ),
    .wr_gnt_i      (alu_wr_gnt    ),
    .done_o        (alu_done      )
  );

endmodule : lane

`default_nettype wire

// ==== tb_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_lane import lane_pkg::*; #(
  parameter int unsigned NrBanks     = 4,
  parameter int unsigned ElemsPerReg = 8,
  parameter int unsigned QueueDepth  = 4
) ();

  // The tests take about 4000 cycles
  localparam int unsigned TimeoutCycles = 20000;
  localparam logic [31:0] Seed          = 32'h28f1;
  localparam int unsigned NrRegs        = 32;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  pe_req_t   pe_req;
  logic      pe_req_valid;
  logic      pe_req_ready;
  pe_resp_t  pe_resp;
  logic      ldu_req;
  vrf_wreq_t ldu_result;
  logic      ldu_gnt;
  elen_t     stu_operand;
  logic      stu_valid;
  logic      stu_ready;

  // Reference VRF indexed by register * ElemsPerReg + element
  elen_t       vrf_model [NrRegs*ElemsPerReg];
  elen_t       store_exp [$];
  logic [31:0] stim_rnd;
  logic [31:0] ready_rnd;
  logic        random_ready = 1'b0;
  vid_t        next_id;
  logic        busy;
  vid_t        busy_id;
  int unsigned cycle_cnt;

  lane #(
    .NrBanks    (NrBanks    ),
    .ElemsPerReg(ElemsPerReg),
    .QueueDepth (QueueDepth )
  ) i_lane (
    .clk_i              (clk_i       ),
    .rst_ni             (rst_ni      ),
    .pe_req_i           (pe_req      ),
    .pe_req_valid_i     (pe_req_valid),
    .pe_req_ready_o     (pe_req_ready),
    .pe_resp_o          (pe_resp     ),
    .ldu_result_req_i   (ldu_req     ),
    .ldu_result_i       (ldu_result  ),
    .ldu_result_gnt_o   (ldu_gnt     ),
    .stu_operand_o      (stu_operand ),
    .stu_operand_valid_o(stu_valid   ),
    .stu_operand_ready_i(stu_ready   )
  );

  initial begin
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_error(input string msg);
    abort_run($sformatf("error at %0t ns: %s", $time, msg));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    stim_rnd = lcg_next(stim_rnd);
    return stim_rnd;
  endfunction

  function automatic elen_t rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand32();
    lo = rand32();
    return {hi, lo};
  endfunction

  function automatic vreg_t rand_reg();
    logic [31:0] r;
    r = rand32();
    return r[20:16];
  endfunction

  function automatic vlen_t rand_vl();
    logic [31:0] r;
    r = rand32();
    return vlen_t'((r >> 16) % ElemsPerReg) + vlen_t'(1);
  endfunction

  function automatic int unsigned elem_index(vreg_t r, int unsigned idx);
    return r * ElemsPerReg + idx;
  endfunction

  function automatic elen_t merge_bytes(elen_t old_val, elen_t new_val, strb_t be);
    elen_t res;
    res = old_val;
    for (int i = 0; i < 8; i++) begin
      if (be[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  function automatic elen_t alu_ref(alu_op_e op, elen_t a, elen_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      default: return '0;
    endcase
  endfunction

  function automatic pe_req_t make_req(insn_kind_e kind, alu_op_e op, vreg_t vd,
                                       vreg_t vs1, vreg_t vs2, vlen_t vl);
    pe_req_t r;
    r.id     = next_id;
    r.kind   = kind;
    r.alu_op = op;
    r.vd     = vd;
    r.vs1    = vs1;
    r.vs2    = vs2;
    r.vl     = vl;
    next_id  = next_id + vid_t'(1);
    return r;
  endfunction

  // Starts and ends on a falling edge
  task automatic load_elem(input vreg_t r, input int unsigned idx, input elen_t data,
                           input strb_t be);
    int unsigned mi;
    mi         = elem_index(r, idx);
    ldu_result = '{addr: vaddr_t'(mi), wdata: data, be: be};
    ldu_req    = 1'b1;
    do @(posedge clk_i); while (!ldu_gnt);
    vrf_model[mi] = merge_bytes(vrf_model[mi], data, be);
    @(negedge clk_i);
    ldu_req = 1'b0;
  endtask

  task automatic issue_insn(input pe_req_t req);
    pe_req       = req;
    pe_req_valid = 1'b1;
    do @(posedge clk_i); while (!pe_req_ready);
    @(negedge clk_i);
    pe_req_valid = 1'b0;
    do @(posedge clk_i); while (!pe_resp.done);
    @(negedge clk_i);
  endtask

  task automatic run_alu(input alu_op_e op, input vreg_t vd, input vreg_t vs1,
                         input vreg_t vs2, input vlen_t vl);
    issue_insn(make_req(VALU, op, vd, vs1, vs2, vl));
    // Element i only depends on element i, so vd may alias a source
    for (int i = 0; i < int'(vl); i++) begin
      vrf_model[elem_index(vd, i)] = alu_ref(op, vrf_model[elem_index(vs1, i)],
                                             vrf_model[elem_index(vs2, i)]);
    end
  endtask

  task automatic run_store(input vreg_t vs, input vlen_t vl);
    for (int i = 0; i < int'(vl); i++) begin
      store_exp.push_back(vrf_model[elem_index(vs, i)]);
    end
    issue_insn(make_req(VSTORE, ADD, '0, vs, '0, vl));
    assert (store_exp.size() == 0)
      else report_error($sformatf("store of v%0d is missing %0d elements", vs,
                                  store_exp.size()));
  endtask

  ////////////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    stu_valid && !stu_ready |=> stu_valid && $stable(stu_operand))
    else report_error("store operand changed or dropped while stalled");

  // A second grant for one load would find req already low
  assert property (@(posedge clk_i) ldu_gnt |-> ldu_req)
    else report_error("load grant without a load request");

  assert property (@(posedge clk_i) pe_resp.done |=> !pe_resp.done)
    else report_error("completion pulse longer than one cycle");

  assert property (@(posedge clk_i) !rst_ni |-> !pe_resp.done && !stu_valid && !ldu_gnt)
    else report_error("lane outputs active during reset");

  always @(posedge clk_i) begin : monitor
    elen_t exp_elem;
    if (stu_valid && stu_ready) begin
      assert (store_exp.size() > 0)
        else report_error("store port presented an element beyond vl");
      exp_elem = store_exp.pop_front();
      assert (stu_operand == exp_elem)
        else report_error($sformatf("store data %h, expected %h", stu_operand, exp_elem));
    end
    if (pe_resp.done) begin
      assert (busy) else report_error("completion pulse with no request in flight");
      assert (pe_resp.id == busy_id)
        else report_error($sformatf("completion id %0d, expected %0d", pe_resp.id, busy_id));
      busy = 1'b0;
    end else if (busy) begin
      assert (!pe_req_ready) else report_error("request ready before completion");
    end
    if (pe_req_valid && pe_req_ready) begin
      busy    = 1'b1;
      busy_id = pe_req.id;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      abort_run($sformatf("timeout: tests did not finish within %0d cycles", TimeoutCycles));
    end
  end

  // Store port ready is random only while back-pressure is on
  initial begin
    stu_ready = 1'b1;
    ready_rnd = Seed;
    forever begin
      @(negedge clk_i);
      ready_rnd = lcg_next(ready_rnd);
      stu_ready = random_ready ? ready_rnd[20] : 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  initial begin
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    vreg_t lr;
    vlen_t vl;
    elen_t ld_data [6];
    strb_t ld_be   [6];

    rst_ni       = 1'b0;
    pe_req       = '0;
    pe_req_valid = 1'b0;
    ldu_req      = 1'b0;
    ldu_result   = '0;
    stim_rnd     = Seed;
    next_id      = '0;
    busy         = 1'b0;
    busy_id      = '0;
    cycle_cnt    = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    assert (!pe_resp.done && !stu_valid && !ldu_gnt)
      else report_error("lane outputs active right after reset");

    // Fill the whole VRF, then read some registers back
    for (int r = 0; r < NrRegs; r++) begin
      for (int i = 0; i < ElemsPerReg; i++) begin
        load_elem(vreg_t'(r), i, rand64(), '1);
      end
    end
    for (int n = 0; n < 8; n++) begin
      run_store(rand_reg(), rand_vl());
    end

    random_ready = 1'b1;
    for (int n = 0; n < 8; n++) begin
      run_store(rand_reg(), rand_vl());
    end

    // Partial byte enables
    for (int n = 0; n < 4; n++) begin
      lr = rand_reg();
      for (int k = 0; k < 3; k++) begin
        load_elem(lr, (rand32() >> 16) % ElemsPerReg, rand64(), strb_t'(rand32() >> 8));
      end
      run_store(lr, vlen_t'(ElemsPerReg));
    end

    // Every ALU op with vs1 equal to vs2 in the first round
    for (int op = 0; op < 5; op++) begin
      for (int n = 0; n < 3; n++) begin
        vd  = rand_reg();
        vs1 = rand_reg();
        vs2 = (n == 0) ? vs1 : rand_reg();
        vl  = rand_vl();
        run_alu(alu_op_e'(op), vd, vs1, vs2, vl);
        run_store(vd, vl);
      end
    end

    // Load writes to an unrelated register while the ALU runs
    for (int n = 0; n < 4; n++) begin
      vd  = rand_reg();
      vs1 = rand_reg();
      vs2 = rand_reg();
      vl  = rand_vl();
      do lr = rand_reg(); while (lr == vd || lr == vs1 || lr == vs2);
      for (int k = 0; k < 6; k++) begin
        ld_data[k] = rand64();
        ld_be[k]   = strb_t'(rand32() >> 12);
      end
      fork
        begin
          run_alu(alu_op_e'(n), vd, vs1, vs2, vl);
        end
        begin
          for (int k = 0; k < 6; k++) begin
            load_elem(lr, k % ElemsPerReg, ld_data[k], ld_be[k]);
          end
        end
      join
      run_store(lr, vlen_t'(ElemsPerReg));
      run_store(vd, vl);
    end

    repeat (3) @(negedge clk_i);
    $display("RESULT: PASS");
    $finish;
  end

endmodule : tb_lane

`default_nettype wire

// ==== tb.f ====
lane_pkg.sv
operand_queue.sv
vector_regfile.sv
operand_requester.sv
vector_alu.sv
lane_sequencer.sv
lane.sv
tb_lane.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lane
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
